/* logic/issue_macros.svh */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// reservation station depth and its index width
`define RS_SZ 8
`define RS_IDX_BITS 3

// physical register file
`define PHYS_REG_SZ 32
`define PHYS_IDX_BITS 5

// datapath word
`define DATA_BITS 32

// completion slots per cycle, one per common data bus lane
`define CDB_N 2

// functional unit counts
`define NUM_FU_ALU 2
`define NUM_FU_MULT 1

// completion unit vector holds alu units in the low bits, multipliers above
`define NUM_FU_TOTAL (`NUM_FU_ALU + `NUM_FU_MULT)

`endif

/* logic/issue_pkg.sv */
`include "issue_macros.svh"

package issue_pkg;

    // physical register tag and data word
    typedef logic [`PHYS_IDX_BITS-1:0] phys_idx_t;
    typedef logic [`DATA_BITS-1:0] data_t;

    // unit class of a reservation station entry
    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_type_e;

    // single cycle alu operations
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU
    } alu_func_e;

    // multiplier operations, upper half of the result or not
    typedef enum logic [2-1:0] {
        MULT_MUL, MULT_MULH, MULT_MULHSU, MULT_MULHU
    } mult_func_e;

    // multiply op padded out to the width of the alu op
    typedef struct packed {
        logic [1:0] pad;
        mult_func_e op;
    } mult_func_pad_t;

    // one function word, read as alu or mult depending on fu_type
    typedef union packed {
        alu_func_e alu;
        mult_func_pad_t mult;
    } func_u;

    typedef struct packed {
        logic valid;
        fu_type_e fu_type;
        func_u func;
        phys_idx_t src1;
        logic src1_ready;
        phys_idx_t src2;
        logic src2_ready;
        phys_idx_t dest;
        data_t pc;
    } rs_entry_t;

    // one lane of the common data bus
    typedef struct packed {
        logic valid;
        phys_idx_t tag;
        data_t result;
    } cdb_reg_t;

    typedef struct packed {
        logic valid;
        alu_func_e func;
        phys_idx_t dest;
        data_t pc;
        data_t opa;
        data_t opb;
    } alu_packet_t;

    typedef struct packed {
        logic valid;
        mult_func_e func;
        phys_idx_t dest;
        data_t opa;
        data_t opb;
    } mult_packet_t;

endpackage

/* logic/priority_select.sv */
`include "issue_macros.svh"

module priority_select #(
    parameter int WIDTH = `RS_SZ,
    parameter int REQS = `NUM_FU_ALU
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus
);

    // requests not yet handed to an earlier row
    logic [WIDTH-1:0] remaining;

    always_comb begin
        remaining = req;
        gnt_bus = '0;
        for (int k = 0; k < REQS; k++) begin
            // isolate the lowest set bit of what is left
            gnt_bus[k] = remaining & (~remaining + 1'b1);
            remaining = remaining & ~gnt_bus[k];
        end
    end

    // rows are disjoint, so the OR is the full grant set
    always_comb begin
        gnt = '0;
        for (int k = 0; k < REQS; k++) begin
            gnt = gnt | gnt_bus[k];
        end
    end

endmodule

/* logic/ready_scan.sv */
`include "issue_macros.svh"

module ready_scan (
    input  issue_pkg::rs_entry_t [`RS_SZ-1:0] rs_entries,
    output logic [`RS_SZ-1:0] alu_req,
    output logic [`RS_SZ-1:0] mult_req
);

    import issue_pkg::*;

    // entry holds an instruction whose operands are both available
    logic [`RS_SZ-1:0] entry_ready;

    for (genvar i = 0; i < `RS_SZ; i++) begin : g_scan
        assign entry_ready[i] = rs_entries[i].valid
                              && rs_entries[i].src1_ready
                              && rs_entries[i].src2_ready;

        // split by the class of unit the entry needs
        assign alu_req[i] = entry_ready[i] && (rs_entries[i].fu_type == FU_ALU);
        assign mult_req[i] = entry_ready[i] && (rs_entries[i].fu_type == FU_MULT);
    end

endmodule

/* logic/entry_read.sv */
`include "issue_macros.svh"

module entry_read (
    input  logic [`RS_SZ-1:0] grant,
    input  issue_pkg::rs_entry_t [`RS_SZ-1:0] rs_entries,
    input  logic [`PHYS_REG_SZ-1:0] complete_list,
    input  issue_pkg::cdb_reg_t [`CDB_N-1:0] cdb,
    input  issue_pkg::data_t [1:0] rd_data,
    output issue_pkg::rs_entry_t entry,
    output issue_pkg::phys_idx_t [1:0] rd_idx,
    output issue_pkg::data_t opa,
    output issue_pkg::data_t opb
);

    import issue_pkg::*;

    logic [`RS_IDX_BITS-1:0] idx;
    phys_idx_t src1;
    phys_idx_t src2;

    // one-hot to binary, a zero grant reads entry 0
    always_comb begin
        idx = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (grant[i]) begin
                idx = i[`RS_IDX_BITS-1:0];
            end
        end
    end

    assign entry = rs_entries[idx];
    assign src1 = entry.src1;
    assign src2 = entry.src2;

    // register file ports see the source tags directly
    assign rd_idx[0] = src1;
    assign rd_idx[1] = src2;

    // committed value from the register file, else whatever the cdb carries
    function automatic data_t forward(phys_idx_t tag, data_t rf_word);
        data_t value;
        value = '0;
        if (complete_list[tag]) begin
            value = rf_word;
        end else begin
            // later lanes override earlier ones on a double match
            for (int j = 0; j < `CDB_N; j++) begin
                if (cdb[j].valid && (cdb[j].tag == tag)) begin
                    value = cdb[j].result;
                end
            end
        end
        return value;
    endfunction

    always_comb begin
        opa = forward(src1, rd_data[0]);
        opb = forward(src2, rd_data[1]);
    end

endmodule

/* logic/issue_stage.sv */
`include "issue_macros.svh"

module issue_stage (
    input  logic clock,
    input  logic reset,
    input  issue_pkg::rs_entry_t [`RS_SZ-1:0] rs_entries,
    input  logic [`PHYS_REG_SZ-1:0] complete_list,
    input  issue_pkg::cdb_reg_t [`CDB_N-1:0] cdb,
    input  issue_pkg::data_t [`NUM_FU_ALU-1:0][1:0] alu_rd_data,
    input  issue_pkg::data_t [`NUM_FU_MULT-1:0][1:0] mult_rd_data,
    input  logic [`NUM_FU_MULT-1:0] mult_free,
    input  logic [`NUM_FU_MULT-1:0] mult_cdb_req,
    output issue_pkg::phys_idx_t [`NUM_FU_ALU-1:0][1:0] alu_rd_idx,
    output issue_pkg::phys_idx_t [`NUM_FU_MULT-1:0][1:0] mult_rd_idx,
    output issue_pkg::alu_packet_t [`NUM_FU_ALU-1:0] alu_packets,
    output issue_pkg::mult_packet_t [`NUM_FU_MULT-1:0] mult_packets,
    output logic [`RS_SZ-1:0] rs_issuing,
    output logic [`NUM_FU_MULT-1:0] mult_cdb_gnt,
    output logic [`CDB_N-1:0][`NUM_FU_TOTAL-1:0] complete_gnt
);

    import issue_pkg::*;

    localparam int COMP_W = `RS_SZ + `NUM_FU_MULT;

    logic [`RS_SZ-1:0] alu_req;
    logic [`RS_SZ-1:0] mult_req;

    // entry picks per unit slot, lowest rs index first
    logic [`NUM_FU_ALU-1:0][`RS_SZ-1:0] alu_inst_gnt_bus;
    logic [`NUM_FU_MULT-1:0][`RS_SZ-1:0] mult_inst_gnt_bus;
    // free multiplier picked for each mult slot
    logic [`NUM_FU_MULT-1:0][`NUM_FU_MULT-1:0] mult_fu_gnt_bus;

    // completion arbitration over alu entries and multiplier requests
    logic [COMP_W-1:0] comp_gnt;
    logic [`CDB_N-1:0][COMP_W-1:0] comp_gnt_bus;
    logic [`RS_SZ-1:0] rs_cdb_gnt;

    // grants that actually issue this cycle
    logic [`NUM_FU_ALU-1:0][`RS_SZ-1:0] alu_issue_gnt;
    logic [`NUM_FU_MULT-1:0][`RS_SZ-1:0] mult_issue_gnt;
    logic [`NUM_FU_ALU-1:0] alu_issued;
    logic [`NUM_FU_MULT-1:0] mult_issued;

    rs_entry_t [`NUM_FU_ALU-1:0] alu_entry;
    rs_entry_t [`NUM_FU_MULT-1:0] mult_entry;
    data_t [`NUM_FU_ALU-1:0] alu_opa, alu_opb;
    data_t [`NUM_FU_MULT-1:0] mult_opa, mult_opb;
    mult_packet_t [`NUM_FU_MULT-1:0] mult_slot_pkt;

    logic [`CDB_N-1:0][`NUM_FU_TOTAL-1:0] next_complete_gnt;

    ready_scan u_ready_scan (
        .rs_entries(rs_entries),
        .alu_req(alu_req),
        .mult_req(mult_req)
    );

    priority_select #(.WIDTH(`RS_SZ), .REQS(`NUM_FU_ALU)) u_alu_inst_sel (
        .req(alu_req),
        .gnt(),
        .gnt_bus(alu_inst_gnt_bus)
    );

    priority_select #(.WIDTH(`RS_SZ), .REQS(`NUM_FU_MULT)) u_mult_inst_sel (
        .req(mult_req),
        .gnt(),
        .gnt_bus(mult_inst_gnt_bus)
    );

    priority_select #(.WIDTH(`NUM_FU_MULT), .REQS(`NUM_FU_MULT)) u_mult_fu_sel (
        .req(mult_free),
        .gnt(),
        .gnt_bus(mult_fu_gnt_bus)
    );

    // alu candidates sit in the low bits so they win over multiplier requests
    priority_select #(.WIDTH(COMP_W), .REQS(`CDB_N)) u_comp_sel (
        .req({mult_cdb_req, alu_req}),
        .gnt(comp_gnt),
        .gnt_bus(comp_gnt_bus)
    );

    assign rs_cdb_gnt = comp_gnt[`RS_SZ-1:0];
    assign mult_cdb_gnt = comp_gnt[COMP_W-1:`RS_SZ];

    for (genvar i = 0; i < `NUM_FU_ALU; i++) begin : g_alu
        // needs both an alu slot and a completion slot
        assign alu_issue_gnt[i] = alu_inst_gnt_bus[i] & rs_cdb_gnt;
        assign alu_issued[i] = |alu_issue_gnt[i];

        entry_read u_entry_read (
            .grant(alu_issue_gnt[i]),
            .rs_entries(rs_entries),
            .complete_list(complete_list),
            .cdb(cdb),
            .rd_data(alu_rd_data[i]),
            .entry(alu_entry[i]),
            .rd_idx(alu_rd_idx[i]),
            .opa(alu_opa[i]),
            .opb(alu_opb[i])
        );

        always_comb begin
            alu_packets[i] = '0;
            if (alu_issued[i]) begin
                alu_packets[i].valid = 1'b1;
                alu_packets[i].func = alu_entry[i].func.alu;
                alu_packets[i].dest = alu_entry[i].dest;
                alu_packets[i].pc = alu_entry[i].pc;
                alu_packets[i].opa = alu_opa[i];
                alu_packets[i].opb = alu_opb[i];
            end
        end
    end

    for (genvar i = 0; i < `NUM_FU_MULT; i++) begin : g_mult
        // held back while no multiplier is free for this slot
        assign mult_issue_gnt[i] = (|mult_fu_gnt_bus[i]) ? mult_inst_gnt_bus[i] : '0;
        assign mult_issued[i] = |mult_issue_gnt[i];

        entry_read u_entry_read (
            .grant(mult_issue_gnt[i]),
            .rs_entries(rs_entries),
            .complete_list(complete_list),
            .cdb(cdb),
            .rd_data(mult_rd_data[i]),
            .entry(mult_entry[i]),
            .rd_idx(mult_rd_idx[i]),
            .opa(mult_opa[i]),
            .opb(mult_opb[i])
        );

        always_comb begin
            mult_slot_pkt[i] = '0;
            if (mult_issued[i]) begin
                mult_slot_pkt[i].valid = 1'b1;
                mult_slot_pkt[i].func = mult_entry[i].func.mult.op;
                mult_slot_pkt[i].dest = mult_entry[i].dest;
                mult_slot_pkt[i].opa = mult_opa[i];
                mult_slot_pkt[i].opb = mult_opb[i];
            end
        end
    end

    // steer each slot's packet to the multiplier it was granted
    always_comb begin
        mult_packets = '0;
        for (int u = 0; u < `NUM_FU_MULT; u++) begin
            for (int i = 0; i < `NUM_FU_MULT; i++) begin
                if (mult_fu_gnt_bus[i][u]) begin
                    mult_packets[u] = mult_slot_pkt[i];
                end
            end
        end
    end

    always_comb begin
        rs_issuing = '0;
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            rs_issuing = rs_issuing | alu_issue_gnt[i];
        end
        for (int i = 0; i < `NUM_FU_MULT; i++) begin
            rs_issuing = rs_issuing | mult_issue_gnt[i];
        end
    end

    // translate each completion row from rs/request space into unit space
    // an alu row only counts if that entry really issued on some alu
    always_comb begin
        next_complete_gnt = '0;
        for (int k = 0; k < `CDB_N; k++) begin
            for (int i = 0; i < `NUM_FU_ALU; i++) begin
                next_complete_gnt[k][i] = |(comp_gnt_bus[k][`RS_SZ-1:0] & alu_issue_gnt[i]);
            end
            for (int m = 0; m < `NUM_FU_MULT; m++) begin
                next_complete_gnt[k][`NUM_FU_ALU+m] = comp_gnt_bus[k][`RS_SZ+m];
            end
        end
    end

    // completion grants reach the cdb one cycle after issue
    always_ff @(posedge clock) begin
        if (reset) begin
            complete_gnt <= '0;
        end else begin
            complete_gnt <= next_complete_gnt;
        end
    end

endmodule

/* dv/issue_stage_chk.sv */
`include "issue_macros.svh"

module issue_stage_chk (
    input logic clock,
    input logic reset,
    input issue_pkg::rs_entry_t [`RS_SZ-1:0] rs_entries,
    input logic [`NUM_FU_MULT-1:0] mult_free,
    input logic [`NUM_FU_MULT-1:0] mult_cdb_gnt,
    input issue_pkg::alu_packet_t [`NUM_FU_ALU-1:0] alu_packets,
    input issue_pkg::mult_packet_t [`NUM_FU_MULT-1:0] mult_packets,
    input logic [`RS_SZ-1:0] rs_issuing,
    input logic [`CDB_N-1:0][`NUM_FU_TOTAL-1:0] complete_gnt
);

    timeunit 1ns;
    timeprecision 1ps;

    import issue_pkg::*;

    // failures seen so far, read by the testbench at the end
    int fail_count = 0;

    logic [`RS_SZ-1:0] ready_alu;
    logic [`RS_SZ-1:0] ready_mult;
    logic [`RS_SZ-1:0] lowest_alu;
    logic [`NUM_FU_ALU-1:0] alu_valid;
    logic [`NUM_FU_MULT-1:0] mult_valid;
    // OR of all completion rows, in unit space
    logic [`NUM_FU_TOTAL-1:0] gnt_units;
    logic rows_onehot;
    int gnt_bits;

    always_comb begin
        lowest_alu = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            ready_alu[i] = rs_entries[i].valid && rs_entries[i].src1_ready
                && rs_entries[i].src2_ready && (rs_entries[i].fu_type == FU_ALU);
            ready_mult[i] = rs_entries[i].valid && rs_entries[i].src1_ready
                && rs_entries[i].src2_ready && (rs_entries[i].fu_type == FU_MULT);
        end
        // walk down so the lowest ready alu entry is the last one kept
        for (int i = `RS_SZ - 1; i >= 0; i--) begin
            if (ready_alu[i]) begin
                lowest_alu = '0;
                lowest_alu[i] = 1'b1;
            end
        end
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            alu_valid[i] = alu_packets[i].valid;
        end
        for (int u = 0; u < `NUM_FU_MULT; u++) begin
            mult_valid[u] = mult_packets[u].valid;
        end
        gnt_units = '0;
        gnt_bits = 0;
        rows_onehot = 1'b1;
        for (int k = 0; k < `CDB_N; k++) begin
            gnt_units = gnt_units | complete_gnt[k];
            gnt_bits = gnt_bits + $countones(complete_gnt[k]);
            rows_onehot = rows_onehot && $onehot0(complete_gnt[k]);
        end
    end

    // only ready entries leave the station
    issue_only_ready: assert property (@(posedge clock) disable iff (reset)
        (rs_issuing & ~(ready_alu | ready_mult)) == '0)
        else begin
            fail_count++;
            $error("entry marked issuing without being valid and ready");
        end

    // bounded by unit count, and alu issue by completion slots
    issue_bounded: assert property (@(posedge clock) disable iff (reset)
        ($countones(rs_issuing) <= `NUM_FU_TOTAL)
        && ($countones(rs_issuing & ready_alu) <= `CDB_N))
        else begin
            fail_count++;
            $error("too many entries issued in one cycle");
        end

    // alu candidates outrank multiplier requests, so the oldest slot never starves
    lowest_alu_issues: assert property (@(posedge clock) disable iff (reset)
        (|ready_alu) |-> (|(rs_issuing & lowest_alu)))
        else begin
            fail_count++;
            $error("lowest ready alu entry did not issue");
        end

    mult_needs_free: assert property (@(posedge clock) disable iff (reset)
        ((mult_valid & ~mult_free) == '0)
        && ((|mult_free) || ((rs_issuing & ready_mult) == '0)))
        else begin
            fail_count++;
            $error("multiply issued to a busy multiplier");
        end

    // rows one-hot, no unit granted twice, never more than the bus width
    complete_shape: assert property (@(posedge clock) disable iff (reset)
        rows_onehot && (gnt_bits == $countones(gnt_units)) && (gnt_bits <= `CDB_N))
        else begin
            fail_count++;
            $error("completion grant rows malformed");
        end

    complete_follows: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) |-> gnt_units == $past({mult_cdb_gnt, alu_valid}))
        else begin
            fail_count++;
            $error("completion grants differ from last cycle's issue");
        end

    complete_reset: assert property (@(posedge clock) reset |=> complete_gnt == '0)
        else begin
            fail_count++;
            $error("completion grants not cleared by reset");
        end

endmodule

/* dv/issue_stage_tb.sv */
`include "issue_macros.svh"

module issue_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import issue_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_CYCLES = 400;
    localparam int DIRECTED_CYCLES = 20;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + RANDOM_CYCLES);

    logic clock = 1'b0;
    logic reset;
    rs_entry_t [`RS_SZ-1:0] rs_entries;
    logic [`PHYS_REG_SZ-1:0] complete_list;
    cdb_reg_t [`CDB_N-1:0] cdb;
    data_t [`NUM_FU_ALU-1:0][1:0] alu_rd_data;
    data_t [`NUM_FU_MULT-1:0][1:0] mult_rd_data;
    logic [`NUM_FU_MULT-1:0] mult_free;
    logic [`NUM_FU_MULT-1:0] mult_cdb_req;
    phys_idx_t [`NUM_FU_ALU-1:0][1:0] alu_rd_idx;
    phys_idx_t [`NUM_FU_MULT-1:0][1:0] mult_rd_idx;
    alu_packet_t [`NUM_FU_ALU-1:0] alu_packets;
    mult_packet_t [`NUM_FU_MULT-1:0] mult_packets;
    logic [`RS_SZ-1:0] rs_issuing;
    logic [`NUM_FU_MULT-1:0] mult_cdb_gnt;
    logic [`CDB_N-1:0][`NUM_FU_TOTAL-1:0] complete_gnt;

    int mismatches = 0;

    issue_stage uut (.*);

    bind issue_stage issue_stage_chk u_chk (
        .clock(clock),
        .reset(reset),
        .rs_entries(rs_entries),
        .mult_free(mult_free),
        .mult_cdb_gnt(mult_cdb_gnt),
        .alu_packets(alu_packets),
        .mult_packets(mult_packets),
        .rs_issuing(rs_issuing),
        .complete_gnt(complete_gnt)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // register file contents, a scramble of the full index
    function automatic data_t rf_word(phys_idx_t idx);
        return 32'h9e37_79b9 * ({27'd0, idx} + 32'd1);
    endfunction

    always_comb begin
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            alu_rd_data[i][0] = rf_word(alu_rd_idx[i][0]);
            alu_rd_data[i][1] = rf_word(alu_rd_idx[i][1]);
        end
        for (int i = 0; i < `NUM_FU_MULT; i++) begin
            mult_rd_data[i][0] = rf_word(mult_rd_idx[i][0]);
            mult_rd_data[i][1] = rf_word(mult_rd_idx[i][1]);
        end
    end

    // top bit says whether the tag resolves at all this cycle
    function automatic logic [32:0] operand_model(phys_idx_t tag);
        logic [32:0] res;
        res = '0;
        if (complete_list[tag]) begin
            res = {1'b1, rf_word(tag)};
        end else begin
            // higher lane wins
            for (int j = 0; j < `CDB_N; j++) begin
                if (cdb[j].valid && (cdb[j].tag == tag)) begin
                    res = {1'b1, cdb[j].result};
                end
            end
        end
        return res;
    endfunction

    task automatic compare_word(string what, int slot, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s on slot %0d, got %h, expected %h",
                $time, what, slot, got, exp);
        end
    endtask

    task automatic check_operand(string what, int slot, data_t got, phys_idx_t tag);
        logic [32:0] model;
        model = operand_model(tag);
        if (model[32]) begin
            compare_word(what, slot, got, model[31:0]);
        end
    endtask

    task automatic drive_inputs(bit mult_busy, bit flood);
        rs_entry_t e;
        for (int i = 0; i < `RS_SZ; i++) begin
            e.valid = flood || (($urandom % 4) != 0);
            e.fu_type = fu_type_e'(1'($urandom));
            if (e.fu_type == FU_ALU) begin
                e.func.alu = alu_func_e'(4'($urandom % 10));
            end else begin
                e.func.mult.pad = 2'b00;
                e.func.mult.op = mult_func_e'(2'($urandom));
            end
            e.src1 = phys_idx_t'($urandom);
            e.src1_ready = flood || (($urandom % 4) != 0);
            e.src2 = phys_idx_t'($urandom);
            e.src2_ready = flood || (($urandom % 4) != 0);
            e.dest = phys_idx_t'($urandom);
            e.pc = $urandom;
            rs_entries[i] = e;
        end
        complete_list = `PHYS_REG_SZ'($urandom);
        for (int j = 0; j < `CDB_N; j++) begin
            cdb[j].valid = 1'($urandom);
            // aim lanes at live source tags half the time so forwarding is hit
            if (($urandom % 2) != 0) begin
                cdb[j].tag = rs_entries[$urandom % `RS_SZ].src2;
            end else begin
                cdb[j].tag = phys_idx_t'($urandom);
            end
            cdb[j].result = $urandom;
        end
        mult_free = mult_busy ? '0 : `NUM_FU_MULT'($urandom);
        mult_cdb_req = flood ? '1 : `NUM_FU_MULT'($urandom);
    endtask

    // expected issue per slot from the ready entries and free multipliers
    task automatic check_packets();
        int alu_q[$];
        int mult_q[$];
        int free_q[$];
        int slot;
        int slots_left;
        rs_entry_t e;
        for (int i = 0; i < `RS_SZ; i++) begin
            e = rs_entries[i];
            if (e.valid && e.src1_ready && e.src2_ready) begin
                if (e.fu_type == FU_ALU) begin
                    alu_q.push_back(i);
                end else begin
                    mult_q.push_back(i);
                end
            end
        end
        for (int u = 0; u < `NUM_FU_MULT; u++) begin
            if (mult_free[u]) begin
                free_q.push_back(u);
            end
        end
        for (int s = 0; s < `NUM_FU_ALU; s++) begin
            if ((s < alu_q.size()) && (s < `CDB_N)) begin
                e = rs_entries[alu_q[s]];
                compare_word("alu valid", s, 32'(alu_packets[s].valid), 32'd1);
                compare_word("alu func", s, 32'(alu_packets[s].func), 32'(e.func.alu));
                compare_word("alu dest", s, 32'(alu_packets[s].dest), 32'(e.dest));
                compare_word("alu pc", s, alu_packets[s].pc, e.pc);
                compare_word("alu rd idx a", s, 32'(alu_rd_idx[s][0]), 32'(e.src1));
                compare_word("alu rd idx b", s, 32'(alu_rd_idx[s][1]), 32'(e.src2));
                check_operand("alu opa", s, alu_packets[s].opa, e.src1);
                check_operand("alu opb", s, alu_packets[s].opb, e.src2);
            end else begin
                compare_word("alu valid", s, 32'(alu_packets[s].valid), 32'd0);
            end
        end
        for (int u = 0; u < `NUM_FU_MULT; u++) begin
            slot = -1;
            for (int i = 0; i < free_q.size(); i++) begin
                if (free_q[i] == u) begin
                    slot = i;
                end
            end
            if ((slot >= 0) && (slot < mult_q.size())) begin
                e = rs_entries[mult_q[slot]];
                compare_word("mult valid", u, 32'(mult_packets[u].valid), 32'd1);
                compare_word("mult func", u, 32'(mult_packets[u].func), 32'(e.func.mult.op));
                compare_word("mult dest", u, 32'(mult_packets[u].dest), 32'(e.dest));
                compare_word("mult rd idx a", u, 32'(mult_rd_idx[slot][0]), 32'(e.src1));
                compare_word("mult rd idx b", u, 32'(mult_rd_idx[slot][1]), 32'(e.src2));
                check_operand("mult opa", u, mult_packets[u].opa, e.src1);
                check_operand("mult opb", u, mult_packets[u].opb, e.src2);
            end else begin
                compare_word("mult valid", u, 32'(mult_packets[u].valid), 32'd0);
            end
        end
        // every ready alu entry takes a completion slot before any multiplier request
        slots_left = (alu_q.size() < `CDB_N) ? (`CDB_N - alu_q.size()) : 0;
        for (int m = 0; m < `NUM_FU_MULT; m++) begin
            if (mult_cdb_req[m] && (slots_left > 0)) begin
                slots_left--;
                compare_word("mult cdb gnt", m, 32'(mult_cdb_gnt[m]), 32'd1);
            end else begin
                compare_word("mult cdb gnt", m, 32'(mult_cdb_gnt[m]), 32'd0);
            end
        end
    endtask

    initial begin
        bit mult_busy;
        bit flood;
        void'($urandom(1));
        reset = 1'b1;
        rs_entries = '0;
        complete_list = '0;
        cdb = '0;
        mult_free = '0;
        mult_cdb_req = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // random phase, then a busy multiplier, then every completion slot wanted
        for (int n = 0; n < RANDOM_CYCLES + 2 * DIRECTED_CYCLES; n++) begin
            mult_busy = (n >= RANDOM_CYCLES) && (n < RANDOM_CYCLES + DIRECTED_CYCLES);
            flood = (n >= RANDOM_CYCLES + DIRECTED_CYCLES);
            drive_inputs(mult_busy, flood);
            @(posedge clock);
            check_packets();
            @(negedge clock);
        end
        // one more edge so the last completion grant gets checked
        @(posedge clock);
        @(negedge clock);
        $display("value mismatches: %0d, assertion failures: %0d",
            mismatches, uut.u_chk.fail_count);
        if ((mismatches == 0) && (uut.u_chk.fail_count == 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* issue_stage.f */
+incdir+logic
logic/issue_pkg.sv
logic/priority_select.sv
logic/ready_scan.sv
logic/entry_read.sv
logic/issue_stage.sv
dv/issue_stage_chk.sv
dv/issue_stage_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
    -f issue_stage.f --top-module issue_stage_tb -o issue_stage_sim
status=0
./obj_dir/issue_stage_sim +verilator+error+limit+100000 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "CHECKS FAILED" sim.log || [ "$status" -ne 0 ]; then
    exit 1
fi
exit 0
